// ==== ooo_pkg.sv ====
/*
 * ooo_pkg
 * shared widths, opcode encoding and the reorder-buffer entry layout
 * for the in-order-retirement core slice
 */
`default_nettype none

package ooo_pkg;

    // datapath and register file sizes
    localparam int xlen      = 32;
    localparam int reg_count = 16;

    typedef logic [3:0] reg_idx_t;

    // instruction opcodes
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_beq,
        op_halt
    } opcode_t;

    // one reorder-buffer slot
    typedef struct packed {
        logic            valid;
        logic            ready;
        opcode_t         opcode;
        reg_idx_t        dest;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] value;
        logic            predict_taken;
        logic            mispredict;
        // correct fetch pc, only meaningful for branches
        logic [xlen-1:0] redirect_pc;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== cdb_if.sv ====
/*
 * cdb_if
 * common data bus carrying one execution result per cycle
 * back to the reorder buffer
 */
`timescale 1ns/10ps
`default_nettype none

interface cdb_if #(
    parameter int ROB_DEPTH = 8
);
    import ooo_pkg::*;

    localparam int tag_w = $clog2(ROB_DEPTH);

    logic             valid;
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  value;
    // branch outcome
    logic             taken;
    logic [xlen-1:0]  target;

    modport exec (output valid, tag, value, taken, target);
    modport rob  (input valid, tag, value, taken, target);

endinterface

`default_nettype wire

// ==== dispatch_if.sv ====
/*
 * dispatch_if
 * one accepted instruction from the dispatch control to the
 * reorder buffer and the execution pipeline, plus the tail tag and
 * full flag returned by the reorder buffer
 */
`timescale 1ns/10ps
`default_nettype none

interface dispatch_if #(
    parameter int ROB_DEPTH = 8
);
    import ooo_pkg::*;

    localparam int tag_w = $clog2(ROB_DEPTH);

    logic             valid;
    logic [tag_w-1:0] tag;
    opcode_t          opcode;
    logic [xlen-1:0]  operand_a;
    logic [xlen-1:0]  operand_b;
    reg_idx_t         dest;
    logic [xlen-1:0]  pc;
    logic             predict_taken;
    logic             full;

    modport ctrl (
        output valid, opcode, operand_a, operand_b, dest, pc, predict_taken,
        input  full, tag
    );
    modport rob (
        input  valid, opcode, operand_a, operand_b, dest, pc, predict_taken,
        output full, tag
    );
    // branch target needs the pc as well as the operands
    modport exec (input valid, tag, opcode, operand_a, operand_b, pc);

endinterface

`default_nettype wire

// ==== dispatch_ctrl.sv ====
/*
 * dispatch_ctrl
 * four-phase req/ack dispatch port; issues one instruction per
 * handshake into the reorder buffer and the execution pipeline,
 * holding off while the buffer is full, the core is halted or a
 * squash is in progress
 */
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      req,
    output logic                      ack,
    input  ooo_pkg::opcode_t          opcode,
    input  logic [ooo_pkg::xlen-1:0]  operand_a,
    input  logic [ooo_pkg::xlen-1:0]  operand_b,
    input  ooo_pkg::reg_idx_t         dest,
    input  logic [ooo_pkg::xlen-1:0]  pc,
    input  logic                      predict_taken,
    input  logic                      squash,
    input  logic                      halted,
    dispatch_if.ctrl                  dispatch
);
    import ooo_pkg::*;

    typedef enum logic {
        idle,
        wait_release
    } state_t;

    state_t state;
    logic   accept;

    ////////////////////
    // accept decision
    ////////////////////

    // one-cycle issue pulse only from idle with a fresh req
    assign accept = (state == idle) && req && !ack && !dispatch.full
                    && !halted && !squash;

    assign dispatch.valid         = accept;
    assign dispatch.opcode        = opcode;
    assign dispatch.operand_a     = operand_a;
    assign dispatch.operand_b     = operand_b;
    assign dispatch.dest          = dest;
    assign dispatch.pc            = pc;
    assign dispatch.predict_taken = predict_taken;

    ////////////////////
    // handshake FSM
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // ack left high by a squash drops once req is released
                    if (ack && !req) begin
                        ack <= 1'b0;
                    end else if (accept) begin
                        ack   <= 1'b1;
                        state <= wait_release;
                    end
                end
                wait_release: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= idle;
                    end else if (squash) begin
                        // ack stays up so the same req is not taken twice
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
/*
 * exec_unit
 * fixed three-stage execution pipeline; computes arithmetic results
 * and branch outcomes and broadcasts them on the common data bus
 * three cycles after dispatch
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
    parameter int ROB_DEPTH = 8
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    dispatch_if.exec  dispatch,
    cdb_if.exec       cdb
);
    import ooo_pkg::*;

    localparam int tag_w = $clog2(ROB_DEPTH);

    // stage 1 holds the operands, stages 2 and 3 the result
    logic             s1_valid, s2_valid, s3_valid;
    logic [tag_w-1:0] s1_tag, s2_tag, s3_tag;
    opcode_t          s1_opcode;
    logic [xlen-1:0]  s1_a, s1_b, s1_pc;
    logic [xlen-1:0]  s2_value, s3_value;
    logic             s2_taken, s3_taken;
    logic [xlen-1:0]  s2_target, s3_target;

    logic [xlen-1:0]  alu_value;
    logic             alu_taken;
    logic [xlen-1:0]  alu_target;

    always_comb begin
        alu_value  = '0;
        alu_taken  = 1'b0;
        alu_target = s1_pc + xlen'(4);
        case (s1_opcode)
            op_add: alu_value = s1_a + s1_b;
            op_sub: alu_value = s1_a - s1_b;
            op_xor: alu_value = s1_a ^ s1_b;
            op_beq: begin
                alu_taken = (s1_a == '0);
                if (alu_taken) begin
                    alu_target = s1_pc + s1_b;
                end
            end
            // halt carries no result
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= dispatch.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_tag    <= dispatch.tag;
        s1_opcode <= dispatch.opcode;
        s1_a      <= dispatch.operand_a;
        s1_b      <= dispatch.operand_b;
        s1_pc     <= dispatch.pc;
        s2_tag    <= s1_tag;
        s2_value  <= alu_value;
        s2_taken  <= alu_taken;
        s2_target <= alu_target;
        s3_tag    <= s2_tag;
        s3_value  <= s2_value;
        s3_taken  <= s2_taken;
        s3_target <= s2_target;
    end

    assign cdb.valid  = s3_valid;
    assign cdb.tag    = s3_tag;
    assign cdb.value  = s3_value;
    assign cdb.taken  = s3_taken;
    assign cdb.target = s3_target;

endmodule

`default_nettype wire

// ==== rob.sv ====
/*
 * rob
 * circular reorder buffer; allocates at the tail, marks entries ready
 * from the common data bus and retires the head in program order.
 * a retiring mispredicted branch squashes every younger entry and a
 * retiring halt latches the halted flag
 */
`timescale 1ns/10ps
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    dispatch_if.rob                   dispatch,
    cdb_if.rob                        cdb,
    output logic                      retire_valid,
    output logic [ooo_pkg::xlen-1:0]  retire_pc,
    output ooo_pkg::reg_idx_t         retire_dest,
    output logic [ooo_pkg::xlen-1:0]  retire_value,
    output logic                      write_enable,
    output ooo_pkg::reg_idx_t         write_idx,
    output logic [ooo_pkg::xlen-1:0]  write_data,
    output logic                      squash,
    output logic [ooo_pkg::xlen-1:0]  redirect_pc,
    output logic                      halted
);
    import ooo_pkg::*;

    localparam int tag_w = $clog2(ROB_DEPTH);

    rob_entry_t       entries [ROB_DEPTH];
    rob_entry_t       head_entry;
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;
    logic             push;
    logic             is_arith;

    ////////////////////
    // retire side
    ////////////////////

    assign head_entry = entries[head];
    assign push       = dispatch.valid;

    assign dispatch.full = (count == (tag_w + 1)'(ROB_DEPTH));
    assign dispatch.tag  = tail;

    assign retire_valid = head_entry.valid && head_entry.ready;
    assign retire_pc    = head_entry.pc;
    assign retire_dest  = head_entry.dest;
    assign retire_value = head_entry.value;

    assign is_arith     = head_entry.opcode inside {op_add, op_sub, op_xor};
    // register 0 is never written
    assign write_enable = retire_valid && is_arith && (head_entry.dest != '0);
    assign write_idx    = head_entry.dest;
    assign write_data   = head_entry.value;

    assign squash      = retire_valid && head_entry.mispredict;
    assign redirect_pc = head_entry.redirect_pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (retire_valid && (head_entry.opcode == op_halt)) begin
            halted <= 1'b1;
        end
    end

    ////////////////////
    // buffer update
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (push) begin
                entries[tail] <= '{
                    valid:         1'b1,
                    ready:         1'b0,
                    opcode:        dispatch.opcode,
                    dest:          dispatch.dest,
                    pc:            dispatch.pc,
                    value:         '0,
                    predict_taken: dispatch.predict_taken,
                    mispredict:    1'b0,
                    redirect_pc:   '0
                };
                tail <= (tail == tag_w'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            // results for squashed or free slots are dropped
            if (cdb.valid && entries[cdb.tag].valid) begin
                entries[cdb.tag].ready       <= 1'b1;
                entries[cdb.tag].value       <= cdb.value;
                entries[cdb.tag].mispredict  <= (entries[cdb.tag].opcode == op_beq)
                    && (cdb.taken != entries[cdb.tag].predict_taken);
                entries[cdb.tag].redirect_pc <= cdb.target;
            end
            if (retire_valid) begin
                entries[head].valid <= 1'b0;
                entries[head].ready <= 1'b0;
                head <= (head == tag_w'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== arch_regfile.sv ====
/*
 * arch_regfile
 * architectural register file, written at retirement; one
 * combinational read port with write-through bypass
 */
`timescale 1ns/10ps
`default_nettype none

module arch_regfile (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_enable,
    input  ooo_pkg::reg_idx_t         write_idx,
    input  logic [ooo_pkg::xlen-1:0]  write_data,
    input  ooo_pkg::reg_idx_t         read_idx,
    output logic [ooo_pkg::xlen-1:0]  read_data
);
    import ooo_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_idx != '0)) begin
            regs[write_idx] <= write_data;
        end
    end

    // r0 reads zero and a retiring write is seen in the same cycle
    always_comb begin
        if (read_idx == '0) begin
            read_data = '0;
        end else if (write_enable && (write_idx == read_idx)) begin
            read_data = write_data;
        end else begin
            read_data = regs[read_idx];
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
/*
 * ooo_core
 * top level of the core slice: dispatch control, execution pipeline,
 * reorder buffer and architectural register file behind plain ports
 */
`timescale 1ns/10ps
`default_nettype none

module ooo_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_req,
    input  ooo_pkg::opcode_t          dispatch_opcode,
    input  logic [ooo_pkg::xlen-1:0]  dispatch_operand_a,
    input  logic [ooo_pkg::xlen-1:0]  dispatch_operand_b,
    input  ooo_pkg::reg_idx_t         dispatch_dest,
    input  logic [ooo_pkg::xlen-1:0]  dispatch_pc,
    input  logic                      dispatch_predict_taken,
    input  ooo_pkg::reg_idx_t         reg_read_idx,
    output logic                      dispatch_ack,
    output logic                      retire_valid,
    output logic [ooo_pkg::xlen-1:0]  retire_pc,
    output ooo_pkg::reg_idx_t         retire_dest,
    output logic [ooo_pkg::xlen-1:0]  retire_value,
    output logic                      squash,
    output logic [ooo_pkg::xlen-1:0]  redirect_pc,
    output logic                      halted,
    output logic [ooo_pkg::xlen-1:0]  reg_read_data
);
    import ooo_pkg::*;

    // retirement write into the register file
    logic            write_enable;
    reg_idx_t        write_idx;
    logic [xlen-1:0] write_data;

    dispatch_if #(.ROB_DEPTH(ROB_DEPTH)) dispatch_bus ();
    cdb_if      #(.ROB_DEPTH(ROB_DEPTH)) cdb_bus ();

    dispatch_ctrl dispatch_ctrl_inst (
        .clock         (clock),
        .reset         (reset),
        .req           (dispatch_req),
        .ack           (dispatch_ack),
        .opcode        (dispatch_opcode),
        .operand_a     (dispatch_operand_a),
        .operand_b     (dispatch_operand_b),
        .dest          (dispatch_dest),
        .pc            (dispatch_pc),
        .predict_taken (dispatch_predict_taken),
        .squash        (squash),
        .halted        (halted),
        .dispatch      (dispatch_bus.ctrl)
    );

    exec_unit #(.ROB_DEPTH(ROB_DEPTH)) exec_unit_inst (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch_bus.exec),
        .cdb      (cdb_bus.exec)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_inst (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch_bus.rob),
        .cdb          (cdb_bus.rob),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_dest  (retire_dest),
        .retire_value (retire_value),
        .write_enable (write_enable),
        .write_idx    (write_idx),
        .write_data   (write_data),
        .squash       (squash),
        .redirect_pc  (redirect_pc),
        .halted       (halted)
    );

    arch_regfile arch_regfile_inst (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .write_idx    (write_idx),
        .write_data   (write_data),
        .read_idx     (reg_read_idx),
        .read_data    (reg_read_data)
    );

endmodule

`default_nettype wire

// ==== tb_ooo_core.sv ====
/*
 * tb_ooo_core
 * table-driven testbench for the core slice; rows go through the
 * four-phase dispatch port and a reference model checks the retire
 * stream, squash, redirect, halt and register file contents
 */
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int clk_period  = 40;
    localparam int num_rows    = 37;
    localparam int drain_limit = 100;
    // rows plus the extra one sent after the halt
    localparam int watchdog_cycles = (num_rows + 1) * 40;

    logic            clock;
    logic            reset;
    logic            dispatch_req;
    opcode_t         dispatch_opcode;
    logic [xlen-1:0] dispatch_operand_a;
    logic [xlen-1:0] dispatch_operand_b;
    reg_idx_t        dispatch_dest;
    logic [xlen-1:0] dispatch_pc;
    logic            dispatch_predict_taken;
    reg_idx_t        reg_read_idx;
    logic            dispatch_ack;
    logic            retire_valid;
    logic [xlen-1:0] retire_pc;
    reg_idx_t        retire_dest;
    logic [xlen-1:0] retire_value;
    logic            squash;
    logic [xlen-1:0] redirect_pc;
    logic            halted;
    logic [xlen-1:0] reg_read_data;

    // stimulus table with model results
    opcode_t         tbl_opcode [num_rows + 1];
    logic [xlen-1:0] tbl_a [num_rows + 1];
    logic [xlen-1:0] tbl_b [num_rows + 1];
    reg_idx_t        tbl_dest [num_rows + 1];
    logic [xlen-1:0] tbl_pc [num_rows + 1];
    logic            tbl_pred [num_rows + 1];
    int              tbl_test [num_rows + 1];
    logic [xlen-1:0] exp_value [num_rows + 1];
    logic            exp_mispredict [num_rows + 1];
    logic [xlen-1:0] exp_target [num_rows + 1];

    logic [xlen-1:0] shadow [reg_count];
    int              pending [$];
    int              cur_row;
    int              cur_test;
    int              test_errors;
    int              total_errors;
    int              failed_tests;
    int              tests_run;
    int              squash_count;
    int              retired_count;
    logic            ack_seen;
    logic [31:0]     rng;

    ooo_core #(.ROB_DEPTH(8)) ooo_core_inst (
        .clock                  (clock),
        .reset                  (reset),
        .dispatch_req           (dispatch_req),
        .dispatch_opcode        (dispatch_opcode),
        .dispatch_operand_a     (dispatch_operand_a),
        .dispatch_operand_b     (dispatch_operand_b),
        .dispatch_dest          (dispatch_dest),
        .dispatch_pc            (dispatch_pc),
        .dispatch_predict_taken (dispatch_predict_taken),
        .reg_read_idx           (reg_read_idx),
        .dispatch_ack           (dispatch_ack),
        .retire_valid           (retire_valid),
        .retire_pc              (retire_pc),
        .retire_dest            (retire_dest),
        .retire_value           (retire_value),
        .squash                 (squash),
        .redirect_pc            (redirect_pc),
        .halted                 (halted),
        .reg_read_data          (reg_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [xlen-1:0] model_value(input opcode_t op,
                                                    input logic [xlen-1:0] a,
                                                    input logic [xlen-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] model_target(input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b,
                                                     input logic [xlen-1:0] pc);
        // taken when operand_a is zero
        return (a == '0) ? pc + b : pc + 32'd4;
    endfunction

    task automatic set_row(input int r, input opcode_t op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b, input reg_idx_t dest,
                           input logic pred, input int test_num);
        tbl_opcode[r]     = op;
        tbl_a[r]          = a;
        tbl_b[r]          = b;
        tbl_dest[r]       = dest;
        tbl_pc[r]         = 32'h1000 + 32'(4 * r);
        tbl_pred[r]       = pred;
        tbl_test[r]       = test_num;
        exp_value[r]      = model_value(op, a, b);
        exp_target[r]     = model_target(a, b, tbl_pc[r]);
        exp_mispredict[r] = (op == op_beq) && ((a == '0) != pred);
    endtask

    task automatic build_table();
        opcode_t op;
        logic [xlen-1:0] a;
        // random arithmetic for test 2 and the back-pressure run of test 3
        for (int r = 0; r < 29; r++) begin
            rng = xorshift(rng);
            op  = (rng[1:0] == 2'd0) ? op_add : (rng[1:0] == 2'd1) ? op_sub : op_xor;
            rng = xorshift(rng);
            a   = rng;
            rng = xorshift(rng);
            set_row(r, op, a, rng, reg_idx_t'(rng[7:4]), 1'b0, (r < 20) ? 2 : 3);
        end
        // correctly predicted taken branch and two younger rows
        set_row(29, op_beq, 32'd0, 32'h40, 4'd0, 1'b1, 4);
        set_row(30, op_add, 32'd7, 32'd9, 4'd3, 1'b0, 4);
        set_row(31, op_sub, 32'd50, 32'd8, 4'd4, 1'b0, 4);
        // mispredicted branch with row 33 accepted before the squash
        set_row(32, op_beq, 32'd0, 32'h100, 4'd0, 1'b0, 5);
        set_row(33, op_add, 32'd1, 32'd2, 4'd5, 1'b0, 5);
        set_row(34, op_xor, 32'hff, 32'h0f, 4'd6, 1'b0, 5);
        set_row(35, op_add, 32'd100, 32'd23, 4'd7, 1'b0, 5);
        set_row(36, op_halt, 32'd0, 32'd0, 4'd0, 1'b0, 6);
        set_row(37, op_add, 32'd3, 32'd4, 4'd8, 1'b0, 6);
    endtask

    ////////////////////
    // reporting
    ////////////////////

    task automatic flag_mismatch(input string what, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] expected);
        $display("FAILED at %0t ns: test %0d %s got %h expected %h",
                 $time, cur_test, what, got, expected);
        test_errors++;
    endtask

    task automatic describe_problem(input string msg);
        $display("test %0d at %0t ns: %s", cur_test, $time, msg);
        test_errors++;
    endtask

    // retire stream checker
    always @(negedge clock) begin
        int row;
        if (!reset) begin
            if (dispatch_ack && !ack_seen) begin
                pending.push_back(cur_row);
            end
            if (pending.size() > 8) begin
                describe_problem("more than 8 rows acknowledged but not retired");
            end
            if (retire_valid) begin
                if (pending.size() == 0) begin
                    describe_problem("a row retired with nothing outstanding");
                end else begin
                    row = pending.pop_front();
                    retired_count++;
                    if (retire_pc !== tbl_pc[row]) begin
                        flag_mismatch("retire_pc", retire_pc, tbl_pc[row]);
                    end
                    if (retire_dest !== tbl_dest[row]) begin
                        flag_mismatch("retire_dest", 32'(retire_dest), 32'(tbl_dest[row]));
                    end
                    if (retire_value !== exp_value[row]) begin
                        flag_mismatch("retire_value", retire_value, exp_value[row]);
                    end
                    if (squash !== exp_mispredict[row]) begin
                        flag_mismatch("squash", 32'(squash), 32'(exp_mispredict[row]));
                    end
                    if (exp_mispredict[row] && redirect_pc !== exp_target[row]) begin
                        flag_mismatch("redirect_pc", redirect_pc, exp_target[row]);
                    end
                    if (tbl_opcode[row] inside {op_add, op_sub, op_xor}
                        && tbl_dest[row] != '0) begin
                        shadow[tbl_dest[row]] = exp_value[row];
                    end
                end
            end else if (squash) begin
                describe_problem("squash raised without a retiring branch");
            end
            // everything still outstanding is flushed
            if (squash) begin
                squash_count++;
                pending.delete();
            end
        end
        ack_seen = dispatch_ack;
    end

    ////////////////////
    // drivers
    ////////////////////

    task automatic send_row(input int row, input int max_cycles, output bit acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        cur_row                = row;
        dispatch_opcode        = tbl_opcode[row];
        dispatch_operand_a     = tbl_a[row];
        dispatch_operand_b     = tbl_b[row];
        dispatch_dest          = tbl_dest[row];
        dispatch_pc            = tbl_pc[row];
        dispatch_predict_taken = tbl_pred[row];
        dispatch_req           = 1'b1;
        while (!acked && waited < max_cycles) begin
            @(posedge clock);
            #2;
            if (dispatch_ack) acked = 1'b1;
            waited++;
        end
        dispatch_req = 1'b0;
        while (dispatch_ack) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic drain_pending();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < drain_limit) begin
            @(posedge clock);
            #2;
            waited++;
        end
        if (pending.size() != 0) begin
            describe_problem("acknowledged rows never retired");
        end
    endtask

    task automatic check_registers();
        for (int i = 0; i < reg_count; i++) begin
            reg_read_idx = reg_idx_t'(i);
            @(negedge clock);
            if (reg_read_data !== shadow[i]) begin
                flag_mismatch($sformatf("register %0d", i), reg_read_data, shadow[i]);
            end
            @(posedge clock);
            #2;
        end
    endtask

    task automatic close_test();
        bit acked;
        drain_pending();
        if (cur_test == 2) check_registers();
        if (cur_test >= 2 && cur_test <= 4 && squash_count != 0) begin
            describe_problem("squash seen with no mispredicted branch");
        end
        if (cur_test == 5 && squash_count != 1) begin
            describe_problem("mispredicted branch did not squash exactly once");
        end
        if (cur_test == 6) begin
            if (halted !== 1'b1) describe_problem("halted did not rise after the halt retired");
            send_row(num_rows, 40, acked);
            if (acked) describe_problem("a request was acknowledged while halted");
            if (halted !== 1'b1) describe_problem("halted fell before reset");
        end
        if (test_errors == 0) begin
            $display("test %0d passed", cur_test);
        end else begin
            $display("test %0d failed with %0d errors", cur_test, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
        test_errors  = 0;
        squash_count = 0;
        tests_run++;
    endtask

    initial begin : main
        bit acked;
        reset                  = 1'b1;
        dispatch_req           = 1'b0;
        dispatch_opcode        = op_add;
        dispatch_operand_a     = '0;
        dispatch_operand_b     = '0;
        dispatch_dest          = '0;
        dispatch_pc            = '0;
        dispatch_predict_taken = 1'b0;
        reg_read_idx           = '0;
        cur_row = 0;
        cur_test = 1;
        test_errors = 0;
        total_errors = 0;
        failed_tests = 0;
        tests_run = 0;
        squash_count = 0;
        retired_count = 0;
        ack_seen = 1'b0;
        rng = 32'hadbc;
        for (int i = 0; i < reg_count; i++) shadow[i] = '0;
        build_table();
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;

        // state right after reset
        @(negedge clock);
        if (dispatch_ack !== 1'b0) flag_mismatch("dispatch_ack", 32'(dispatch_ack), 32'd0);
        if (retire_valid !== 1'b0) flag_mismatch("retire_valid", 32'(retire_valid), 32'd0);
        if (squash !== 1'b0) flag_mismatch("squash", 32'(squash), 32'd0);
        if (halted !== 1'b0) flag_mismatch("halted", 32'(halted), 32'd0);
        @(posedge clock);
        #2;
        check_registers();
        close_test();

        cur_test = tbl_test[0];
        for (int r = 0; r < num_rows; r++) begin
            if (tbl_test[r] != cur_test) begin
                close_test();
                cur_test = tbl_test[r];
            end
            send_row(r, 200, acked);
            if (!acked) describe_problem($sformatf("row %0d was never acknowledged", r));
        end
        close_test();

        $display("%0d tests, %0d failed, %0d errors, %0d rows retired",
                 tests_run, failed_tests, total_errors, retired_count);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
ooo_pkg.sv
cdb_if.sv
dispatch_if.sv
dispatch_ctrl.sv
exec_unit.sv
rob.sv
arch_regfile.sv
ooo_core.sv
tb_ooo_core.sv

// ==== Makefile ====
# Verilator build and run for the core slice testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ooo_core
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
